// File: src/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    localparam logic [dataWidth-1:0] haltAddr = 32'h0000_0000;  // fetching here stops the core

    typedef enum logic [5:0] {
        OP_R_TYPE = 6'b000000,
        OP_J      = 6'b000010,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } functE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_LUI, ALU_PASSA
    } aluOpE;

    typedef enum logic [2:0] {
        S_FETCH     = 3'd0,
        S_DECODE    = 3'd1,
        S_EXECUTE   = 3'd2,
        S_MEMORY    = 3'd3,
        S_WRITEBACK = 3'd4,
        S_HALTED    = 3'd7
    } cpuStateE;

    // fields overlap in the encoding, each one kept separately here
    typedef struct packed {
        opcodeE                  opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        functE                   funct;
        logic [15:0]             imm16;
        logic [25:0]             target26;
    } instrFieldsS;

    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } busReqS;

    typedef struct packed {
        logic                 take;
        logic [dataWidth-1:0] target;
    } redirectS;

endpackage

// File: src/mipsAlu.sv
`timescale 1ns/1ns

module mipsAlu (
    input  mipsPkg::aluOpE                op,
    input  logic [mipsPkg::dataWidth-1:0] a,
    input  logic [mipsPkg::dataWidth-1:0] b,
    output logic [mipsPkg::dataWidth-1:0] result,
    output logic                          zero
);

    logic signedLess, unsignedLess;

    assign signedLess   = $signed(a) < $signed(b);
    assign unsignedLess = a < b;

    always_comb begin
        case (op)
            mipsPkg::ALU_ADD:   result = a + b;  // wraps, no overflow trap
            mipsPkg::ALU_SUB:   result = a - b;
            mipsPkg::ALU_AND:   result = a & b;
            mipsPkg::ALU_OR:    result = a | b;
            mipsPkg::ALU_XOR:   result = a ^ b;
            mipsPkg::ALU_SLT:   result = {{(mipsPkg::dataWidth-1){1'b0}}, signedLess};
            mipsPkg::ALU_SLTU:  result = {{(mipsPkg::dataWidth-1){1'b0}}, unsignedLess};
            mipsPkg::ALU_LUI:   result = {b[15:0], 16'b0};
            mipsPkg::ALU_PASSA: result = a;
            default:            result = a + b;
        endcase
    end

    // branches compare through SUB
    assign zero = (result == '0);

endmodule

// File: src/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
    input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
    input  logic                             writeEn,
    input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
    input  logic [mipsPkg::dataWidth-1:0]    writeData,
    output logic [mipsPkg::dataWidth-1:0]    readA,
    output logic [mipsPkg::dataWidth-1:0]    readB,
    output logic [mipsPkg::dataWidth-1:0]    register_v0
);

    logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin  // $zero never changes
            regs[writeAddr] <= writeData;
        end
    end

    assign readA       = regs[rsAddr];
    assign readB       = regs[rtAddr];
    assign register_v0 = regs[2];

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit #(
    parameter logic [mipsPkg::dataWidth-1:0] resetVector = 32'hBFC0_0000
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fetchReq,
    input  logic                          advance,
    input  mipsPkg::redirectS             redirect,
    input  logic                          grantDone,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    output mipsPkg::busReqS               busReq,
    output logic [mipsPkg::dataWidth-1:0] instrWord,
    output logic                          fetchDone,
    output logic                          atHalt
);

    logic [mipsPkg::dataWidth-1:0] pc, pendTarget;
    logic pendValid;  // a target waits for the delay slot to finish

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= resetVector;
            pendValid <= 1'b0;
        end else if (advance) begin
            pc        <= pendValid ? pendTarget : pc + 32'd4;
            pendValid <= redirect.take;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && redirect.take) pendTarget <= redirect.target;
        if (fetchDone) instrWord <= readdata;
    end

    assign busReq.read  = fetchReq;
    assign busReq.write = 1'b0;
    assign busReq.addr  = pc;
    assign busReq.wdata = '0;

    assign fetchDone = grantDone && fetchReq;
    assign atHalt    = (pc == mipsPkg::haltAddr);

endmodule

// File: src/loadStoreUnit.sv
`timescale 1ns/1ns

module loadStoreUnit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          memStart,
    input  logic                          memWrite,
    input  logic [mipsPkg::dataWidth-1:0] memAddr,
    input  logic [mipsPkg::dataWidth-1:0] storeData,
    input  logic                          grantDone,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    output mipsPkg::busReqS               busReq,
    output logic [mipsPkg::dataWidth-1:0] loadData,
    output logic                          memDone
);

    logic pending, pendWrite;
    logic [mipsPkg::dataWidth-1:0] pendAddr, pendData;

    always_ff @(posedge clk) begin
        if (reset)                pending <= 1'b0;
        else if (memStart)        pending <= 1'b1;
        else if (memDone)         pending <= 1'b0;
    end

    // request payload held steady while the slave stalls
    always_ff @(posedge clk) begin
        if (memStart) begin
            pendWrite <= memWrite;
            pendAddr  <= {memAddr[mipsPkg::dataWidth-1:2], 2'b00};
            pendData  <= storeData;
        end
        if (memDone && !pendWrite) loadData <= readdata;
    end

    assign busReq.read  = pending && !pendWrite;
    assign busReq.write = pending && pendWrite;
    assign busReq.addr  = pendAddr;
    assign busReq.wdata = pendData;

    assign memDone = pending && grantDone;

endmodule

// File: src/busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
    input  logic                          clk,
    input  logic                          reset,
    input  mipsPkg::busReqS               fetchReq,
    input  mipsPkg::busReqS               dataReq,
    input  logic                          waitrequest,
    output logic [mipsPkg::dataWidth-1:0] address,
    output logic                          read,
    output logic                          write,
    output logic [mipsPkg::dataWidth-1:0] writedata,
    output logic                          fetchGrantDone,
    output logic                          dataGrantDone
);

    mipsPkg::busReqS sel;
    logic locked, lockedData, selData, selActive;

    // an owner stalled by waitrequest keeps the port, otherwise data wins
    assign selData   = locked ? lockedData : (dataReq.read || dataReq.write);
    assign sel       = selData ? dataReq : fetchReq;
    assign selActive = sel.read || sel.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked     <= 1'b0;
            lockedData <= 1'b0;
        end else if (selActive && waitrequest) begin
            locked     <= 1'b1;
            lockedData <= selData;
        end else begin
            locked     <= 1'b0;
        end
    end

    assign address   = sel.addr;
    assign read      = sel.read;
    assign write     = sel.write;
    assign writedata = sel.wdata;

    assign dataGrantDone  = selData && selActive && !waitrequest;
    assign fetchGrantDone = !selData && selActive && !waitrequest;

endmodule

// File: src/cpuControl.sv
`timescale 1ns/1ns

module cpuControl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [mipsPkg::dataWidth-1:0]     instrWord,
    input  logic                              fetchDone,
    input  logic                              atHalt,
    input  logic                              memDone,
    input  logic [mipsPkg::dataWidth-1:0]     loadData,
    input  logic [mipsPkg::dataWidth-1:0]     readA,
    input  logic [mipsPkg::dataWidth-1:0]     readB,
    input  logic [mipsPkg::dataWidth-1:0]     aluResult,
    input  logic                              aluZero,
    input  logic [mipsPkg::dataWidth-1:0]     pc,  // address of the instruction in flight
    output logic                              fetchReq,
    output logic                              advance,
    output mipsPkg::redirectS                 redirect,
    output logic                              memStart,
    output logic                              memWrite,
    output logic [mipsPkg::dataWidth-1:0]     memAddr,
    output logic [mipsPkg::dataWidth-1:0]     storeData,
    output logic [mipsPkg::regAddrWidth-1:0]  rsAddr,
    output logic [mipsPkg::regAddrWidth-1:0]  rtAddr,
    output mipsPkg::aluOpE                    aluOp,
    output logic [mipsPkg::dataWidth-1:0]     aluA,
    output logic [mipsPkg::dataWidth-1:0]     aluB,
    output logic                              regWrite,
    output logic [mipsPkg::regAddrWidth-1:0]  regWriteAddr,
    output logic [mipsPkg::dataWidth-1:0]     regWriteData,
    output logic                              active
);

    mipsPkg::cpuStateE state;
    mipsPkg::instrFieldsS fields;
    mipsPkg::redirectS nextRedirect;
    logic [mipsPkg::dataWidth-1:0] aluOut, pcPlus4, signImm, zeroImm;
    logic started, isMem, writesReg;

    assign isMem   = (fields.opcode == mipsPkg::OP_LW) || (fields.opcode == mipsPkg::OP_SW);
    assign pcPlus4 = pc + 32'd4;  // delay slot address
    assign signImm = {{16{fields.imm16[15]}}, fields.imm16};
    assign zeroImm = {16'b0, fields.imm16};

    always_comb begin
        aluOp = mipsPkg::ALU_ADD;
        aluB  = signImm;
        writesReg = 1'b0;
        nextRedirect = '{take: 1'b0, target: '0};
        case (fields.opcode)
            mipsPkg::OP_R_TYPE: begin
                aluB = readB;
                writesReg = (fields.funct != mipsPkg::FN_JR);
                case (fields.funct)
                    mipsPkg::FN_SUBU: aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:  aluOp = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT:  aluOp = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLTU: aluOp = mipsPkg::ALU_SLTU;
                    mipsPkg::FN_JR: begin
                        aluOp = mipsPkg::ALU_PASSA;  // jump target comes through from rs
                        nextRedirect = '{take: 1'b1, target: aluResult};
                    end
                    default: aluOp = mipsPkg::ALU_ADD;
                endcase
            end
            mipsPkg::OP_J: nextRedirect = '{take: 1'b1,
                                            target: {pcPlus4[31:28], fields.target26, 2'b00}};
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                aluOp = mipsPkg::ALU_SUB;
                aluB  = readB;
                nextRedirect.take = (fields.opcode == mipsPkg::OP_BEQ) ? aluZero : !aluZero;
                nextRedirect.target = pcPlus4 + {signImm[29:0], 2'b00};
            end
            mipsPkg::OP_SLTI:  begin aluOp = mipsPkg::ALU_SLT;  writesReg = 1'b1; end
            mipsPkg::OP_SLTIU: begin aluOp = mipsPkg::ALU_SLTU; writesReg = 1'b1; end
            mipsPkg::OP_ANDI:  begin aluOp = mipsPkg::ALU_AND; aluB = zeroImm; writesReg = 1'b1; end
            mipsPkg::OP_ORI:   begin aluOp = mipsPkg::ALU_OR;  aluB = zeroImm; writesReg = 1'b1; end
            mipsPkg::OP_XORI:  begin aluOp = mipsPkg::ALU_XOR; aluB = zeroImm; writesReg = 1'b1; end
            mipsPkg::OP_LUI:   begin aluOp = mipsPkg::ALU_LUI; aluB = zeroImm; writesReg = 1'b1; end
            mipsPkg::OP_ADDIU, mipsPkg::OP_LW: writesReg = 1'b1;
            default: ;  // SW uses the sign-extended add
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= mipsPkg::S_FETCH;
            started   <= 1'b0;
            memStart  <= 1'b0;
            redirect  <= '{take: 1'b0, target: '0};
        end else begin
            started  <= 1'b1;  // first fetch waits one cycle after reset
            memStart <= 1'b0;
            case (state)
                mipsPkg::S_FETCH:
                    if (started && atHalt) state <= mipsPkg::S_HALTED;
                    else if (fetchDone)    state <= mipsPkg::S_DECODE;
                mipsPkg::S_DECODE:  state <= mipsPkg::S_EXECUTE;
                mipsPkg::S_EXECUTE: begin
                    redirect <= nextRedirect;
                    memStart <= isMem;  // one pulse on entering MEMORY
                    state    <= mipsPkg::S_MEMORY;
                end
                mipsPkg::S_MEMORY:
                    if (!isMem || memDone) state <= mipsPkg::S_WRITEBACK;
                mipsPkg::S_WRITEBACK: state <= mipsPkg::S_FETCH;
                default: state <= mipsPkg::S_HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mipsPkg::S_DECODE) begin
            fields.opcode   <= mipsPkg::opcodeE'(instrWord[31:26]);
            fields.rs       <= instrWord[25:21];
            fields.rt       <= instrWord[20:16];
            fields.rd       <= instrWord[15:11];
            fields.funct    <= mipsPkg::functE'(instrWord[5:0]);
            fields.imm16    <= instrWord[15:0];
            fields.target26 <= instrWord[25:0];
        end
        if (state == mipsPkg::S_EXECUTE) aluOut <= aluResult;
    end

    assign fetchReq     = (state == mipsPkg::S_FETCH) && started && !atHalt;
    assign advance      = (state == mipsPkg::S_WRITEBACK);
    assign active       = (state != mipsPkg::S_HALTED);
    assign rsAddr       = fields.rs;
    assign rtAddr       = fields.rt;
    assign aluA         = readA;
    assign memAddr      = aluOut;
    assign memWrite     = (fields.opcode == mipsPkg::OP_SW);
    assign storeData    = readB;  // rt stays selected through MEMORY
    assign regWrite     = (state == mipsPkg::S_WRITEBACK) && writesReg;
    assign regWriteAddr = (fields.opcode == mipsPkg::OP_R_TYPE) ? fields.rd : fields.rt;
    assign regWriteData = (fields.opcode == mipsPkg::OP_LW) ? loadData : aluOut;

endmodule

// File: src/mipsCpuBus.sv
`timescale 1ns/1ns

module mipsCpuBus #(
    parameter logic [mipsPkg::dataWidth-1:0] resetVector = 32'hBFC0_0000
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            active,
    output logic [mipsPkg::dataWidth-1:0]   register_v0,
    output logic [mipsPkg::dataWidth-1:0]   address,
    output logic                            read,
    output logic                            write,
    output logic [mipsPkg::dataWidth-1:0]   writedata,
    output logic [mipsPkg::dataWidth/8-1:0] byteenable,
    input  logic                            waitrequest,
    input  logic [mipsPkg::dataWidth-1:0]   readdata
);

    logic [mipsPkg::dataWidth-1:0] instrWord, loadData, readA, readB;
    logic [mipsPkg::dataWidth-1:0] aluResult, aluA, aluB;
    logic [mipsPkg::dataWidth-1:0] memAddr, storeData, regWriteData;
    logic [mipsPkg::regAddrWidth-1:0] rsAddr, rtAddr, regWriteAddr;
    logic fetchDone, atHalt, memDone, aluZero, fetchReq, advance;
    logic memStart, memWrite, regWrite, fetchGrantDone, dataGrantDone;
    mipsPkg::aluOpE aluOp;
    mipsPkg::redirectS redirect;
    mipsPkg::busReqS fetchBusReq, dataBusReq;

    assign byteenable = '1;  // word accesses only

    cpuControl u_control (
        .clk, .reset, .instrWord, .fetchDone, .atHalt, .memDone, .loadData,
        .readA, .readB, .aluResult, .aluZero, .pc(fetchBusReq.addr),
        .fetchReq, .advance, .redirect, .memStart, .memWrite, .memAddr, .storeData,
        .rsAddr, .rtAddr, .aluOp, .aluA, .aluB, .regWrite, .regWriteAddr,
        .regWriteData, .active
    );

    mipsAlu u_alu (.op(aluOp), .a(aluA), .b(aluB), .result(aluResult), .zero(aluZero));

    regFile u_regs (
        .clk, .reset, .rsAddr, .rtAddr, .writeEn(regWrite), .writeAddr(regWriteAddr),
        .writeData(regWriteData), .readA, .readB, .register_v0
    );

    fetchUnit #(.resetVector(resetVector)) u_fetch (
        .clk, .reset, .fetchReq, .advance, .redirect, .grantDone(fetchGrantDone),
        .readdata, .busReq(fetchBusReq), .instrWord, .fetchDone, .atHalt
    );

    loadStoreUnit u_lsu (
        .clk, .reset, .memStart, .memWrite, .memAddr, .storeData,
        .grantDone(dataGrantDone), .readdata, .busReq(dataBusReq), .loadData, .memDone
    );

    busArbiter u_arb (
        .clk, .reset, .fetchReq(fetchBusReq), .dataReq(dataBusReq), .waitrequest,
        .address, .read, .write, .writedata, .fetchGrantDone, .dataGrantDone
    );

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tb/mipsCpuBus_sva.sv
`timescale 1ns/1ns

module mipsCpuBus_sva (
    input logic                          clk,
    input logic                          reset,
    input logic                          active,
    input logic                          read,
    input logic                          write,
    input logic                          waitrequest,
    input logic [mipsPkg::dataWidth-1:0] address,
    input logic [mipsPkg::dataWidth-1:0] writedata
);

    int failCount = 0;

    noReadWrite: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            failCount++;
            $error("read and write high in the same cycle");
        end

    // a stalled request keeps every pin until waitrequest drops
    holdWhileStalled: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata))
        else begin
            failCount++;
            $error("request changed while waitrequest was high");
        end

    wordAligned: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> address[1:0] == 2'b00)
        else begin
            failCount++;
            $error("unaligned bus address");
        end

    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !(read || write))
        else begin
            failCount++;
            $error("bus request after the core halted");
        end

endmodule

// File: tb/tbChecker.sv
`timescale 1ns/1ns

module tbChecker #(
    parameter logic [31:0] resetVector = 32'hBFC0_0000,
    parameter int          progLen     = 62,
    parameter int          dataWords   = 1024
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        active,
    input  logic [31:0] register_v0,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    input  logic        waitrequest,
    input  logic [31:0] code [progLen],
    input  logic [31:0] dataInit [dataWords],
    output int          errorCount,
    output int          readCount,
    output int          writeCount,
    output logic        finished
);

    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic        expWrite [$];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [dataWords];
    int expReads, expWrites, waited;
    logic [31:0] ea, ed;
    logic ew;

    task automatic pushExpected(input logic isWrite, input logic [31:0] addr,
                                input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
        expWrite.push_back(isWrite);
        if (isWrite) expWrites++;
        else expReads++;
    endtask

    // instruction-set model, one instruction per step, delayed redirect
    task automatic runModel;
        logic [31:0] pc, nextPc, seqPc, instr, a, b, simm, zimm, ea2, target, pendTarget;
        logic [4:0] rt, rd;
        logic take, pendValid;
        int steps;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        for (int i = 0; i < dataWords; i++) modelMem[i] = dataInit[i];
        pc = resetVector;
        pendValid = 1'b0;
        pendTarget = '0;
        steps = 0;
        while (pc != mipsPkg::haltAddr && steps < 1000) begin
            pushExpected(1'b0, pc, '0);
            instr = ((pc - resetVector) >> 2) < progLen ? code[(pc - resetVector) >> 2] : '0;
            a = modelRegs[instr[25:21]];
            b = modelRegs[instr[20:16]];
            rt = instr[20:16];
            rd = instr[15:11];
            simm = {{16{instr[15]}}, instr[15:0]};
            zimm = {16'b0, instr[15:0]};
            ea2 = a + simm;
            take = 1'b0;
            target = '0;
            case (instr[31:26])
                mipsPkg::OP_R_TYPE:
                    case (instr[5:0])
                        mipsPkg::FN_ADDU: modelRegs[rd] = a + b;
                        mipsPkg::FN_SUBU: modelRegs[rd] = a - b;
                        mipsPkg::FN_AND:  modelRegs[rd] = a & b;
                        mipsPkg::FN_OR:   modelRegs[rd] = a | b;
                        mipsPkg::FN_XOR:  modelRegs[rd] = a ^ b;
                        mipsPkg::FN_SLT:  modelRegs[rd] = {31'b0, $signed(a) < $signed(b)};
                        mipsPkg::FN_SLTU: modelRegs[rd] = {31'b0, a < b};
                        mipsPkg::FN_JR: begin
                            take = 1'b1;
                            target = a;
                        end
                        default: ;
                    endcase
                mipsPkg::OP_ADDIU: modelRegs[rt] = a + simm;
                mipsPkg::OP_SLTI:  modelRegs[rt] = {31'b0, $signed(a) < $signed(simm)};
                mipsPkg::OP_SLTIU: modelRegs[rt] = {31'b0, a < simm};
                mipsPkg::OP_ANDI:  modelRegs[rt] = a & zimm;
                mipsPkg::OP_ORI:   modelRegs[rt] = a | zimm;
                mipsPkg::OP_XORI:  modelRegs[rt] = a ^ zimm;
                mipsPkg::OP_LUI:   modelRegs[rt] = {instr[15:0], 16'b0};
                mipsPkg::OP_LW: begin
                    pushExpected(1'b0, ea2, '0);
                    modelRegs[rt] = modelMem[ea2[11:2]];
                end
                mipsPkg::OP_SW: begin
                    pushExpected(1'b1, ea2, b);
                    modelMem[ea2[11:2]] = b;
                end
                mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                    take = (instr[31:26] == mipsPkg::OP_BEQ) ? (a == b) : (a != b);
                    target = pc + 32'd4 + {simm[29:0], 2'b00};
                end
                mipsPkg::OP_J: begin
                    take = 1'b1;
                    seqPc = pc + 32'd4;  // region bits come from the delay slot
                    target = {seqPc[31:28], instr[25:0], 2'b00};
                end
                default: ;
            endcase
            modelRegs[0] = '0;
            nextPc = pendValid ? pendTarget : pc + 32'd4;  // delay slot first
            pendValid = take;
            pendTarget = target;
            pc = nextPc;
            steps++;
        end
        if (steps >= 1000) begin
            $display("the reference model did not reach the halt address");
            errorCount++;
        end
    endtask

    // every completed transfer is compared with the next expected one
    always @(posedge clk) begin
        if (!reset && (read || write) && !waitrequest) begin
            if (write) writeCount++;
            else readCount++;
            if (byteenable !== 4'hF) begin
                $display("mismatch at %0t: byteenable %h, expected f", $time, byteenable);
                errorCount++;
            end
            if (expAddr.size() == 0) begin
                $display("unexpected bus transfer at %0t to address %h", $time, address);
                errorCount++;
            end else begin
                ea = expAddr.pop_front();
                ed = expData.pop_front();
                ew = expWrite.pop_front();
                if (write != ew || address != ea || (write && writedata != ed)) begin
                    $display("mismatch at %0t: got write=%0b addr %h data %h, want %0b %h %h",
                             $time, write, address, writedata, ew, ea, ed);
                    errorCount++;
                end
            end
        end
    end

    initial begin
        errorCount = 0;
        readCount  = 0;
        writeCount = 0;
        expReads   = 0;
        expWrites  = 0;
        finished   = 1'b0;
        @(posedge clk);
        runModel;
        waited = 0;
        while (active !== 1'b0 && waited < 20000) begin
            @(posedge clk);
            waited++;
        end
        if (active !== 1'b0) begin
            $display("timeout: the core never dropped active");
            errorCount++;
        end
        repeat (10) @(posedge clk);  // stray transfers would show up here
        if (expAddr.size() != 0) begin
            $display("%0d expected bus transfers never happened", expAddr.size());
            errorCount++;
        end
        if (register_v0 !== modelRegs[2]) begin
            $display("mismatch at %0t: register_v0 %h, expected %h",
                     $time, register_v0, modelRegs[2]);
            errorCount++;
        end
        if (readCount != expReads || writeCount != expWrites) begin
            $display("mismatch at %0t: %0d reads %0d writes, expected %0d reads %0d writes",
                     $time, readCount, writeCount, expReads, expWrites);
            errorCount++;
        end
        finished = 1'b1;
    end

endmodule

// File: tb/tbTop.sv
`timescale 1ns/1ns

module tbTop;

    localparam logic [31:0] resetVector = 32'hBFC0_0000;
    localparam int progLen   = 62;  // 60 random, then jr $0 and its nop
    localparam int dataWords = 1024;

    logic clk, reset, active, read, write, waitrequest, finished;
    logic [31:0] address, writedata, readdata, register_v0;
    logic [3:0] byteenable;
    logic [31:0] code [progLen];
    logic [31:0] dataInit [dataWords];
    logic [31:0] dataMem [dataWords];
    integer seed;
    int stall, limit, errorCount, readCount, writeCount;

    tbClock u_clock (.clk, .reset);

    mipsCpuBus #(.resetVector(resetVector)) i_dut (
        .clk, .reset, .active, .register_v0, .address, .read, .write, .writedata,
        .byteenable, .waitrequest, .readdata
    );

    tbChecker #(
        .resetVector(resetVector), .progLen(progLen), .dataWords(dataWords)
    ) u_checker (
        .clk, .reset, .active, .register_v0, .address, .read, .write, .writedata,
        .byteenable, .waitrequest, .code, .dataInit, .errorCount, .readCount,
        .writeCount, .finished
    );

    bind mipsCpuBus mipsCpuBus_sva u_sva (
        .clk, .reset, .active, .read, .write, .waitrequest, .address, .writedata
    );

    task automatic makeInstr(input int idx, input bit allowCtrl, output logic [31:0] instr,
                             output bit isCtrl);
        int kind, k;
        logic [4:0] rs, rt, rd;
        logic [15:0] imm;
        logic [31:0] target;
        kind = $unsigned($random(seed)) % (allowCtrl ? 20 : 17);
        rs = 1 + $unsigned($random(seed)) % 7;
        rt = 1 + $unsigned($random(seed)) % 7;
        rd = 1 + $unsigned($random(seed)) % 7;
        imm = $random(seed);
        k = 1 + $unsigned($random(seed)) % 3;  // forward skip for branches
        target = resetVector + 4 * (idx + 1 + k);
        isCtrl = (kind >= 17);
        case (kind)
            0:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_ADDU};
            1:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_SUBU};
            2:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_AND};
            3:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_OR};
            4:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_XOR};
            5:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_SLT};
            6:  instr = {6'b0, rs, rt, rd, 5'b0, mipsPkg::FN_SLTU};
            7:  instr = {mipsPkg::OP_ADDIU, rs, rt, imm};
            8:  instr = {mipsPkg::OP_SLTI, rs, rt, imm};
            9:  instr = {mipsPkg::OP_SLTIU, rs, rt, imm};
            10: instr = {mipsPkg::OP_ANDI, rs, rt, imm};
            11: instr = {mipsPkg::OP_ORI, rs, rt, imm};
            12: instr = {mipsPkg::OP_XORI, rs, rt, imm};
            13: instr = {mipsPkg::OP_LUI, 5'd0, rt, imm};
            14: instr = {mipsPkg::OP_LW, 5'd0, rt, 4'b0, imm[9:0], 2'b00};
            15, 16: instr = {mipsPkg::OP_SW, 5'd0, rt, 4'b0, imm[9:0], 2'b00};
            17: instr = {mipsPkg::OP_BEQ, rs, rt, 16'(k)};
            18: instr = {mipsPkg::OP_BNE, rs, rt, 16'(k)};
            default: instr = {mipsPkg::OP_J, target[27:2]};
        endcase
    endtask

    task automatic genProgram;
        bit prevCtrl, isCtrl;
        prevCtrl = 1'b0;
        for (int i = 0; i < 60; i++) begin
            // no control transfer in a delay slot, targets stay inside the program
            makeInstr(i, !prevCtrl && i <= 56, code[i], isCtrl);
            prevCtrl = isCtrl;
        end
        code[60] = {6'b0, 5'd0, 15'd0, mipsPkg::FN_JR};
        code[61] = 32'h0;
    endtask

    function automatic logic [31:0] lookup(input logic [31:0] addr);
        if (addr >= resetVector && addr < resetVector + 4 * progLen)
            return code[(addr - resetVector) >> 2];
        else if (addr < 4 * dataWords)
            return dataMem[addr[11:2]];
        else
            return 32'h0;
    endfunction

    // slave: at least one wait cycle, then 0 to 2 more at random
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
            stall       <= $unsigned($random(seed)) % 3;
        end else if ((read || write) && !waitrequest) begin
            if (write) dataMem[address[11:2]] <= writedata;
            waitrequest <= 1'b1;
            stall       <= $unsigned($random(seed)) % 3;
        end else if (read || write) begin
            if (stall == 0) begin
                waitrequest <= 1'b0;
                readdata    <= lookup(address);
            end else begin
                stall <= stall - 1;
            end
        end
    end

    initial begin
        seed        = 83853;
        waitrequest = 1'b1;
        readdata    = '0;
        stall       = 0;
        for (int i = 0; i < dataWords; i++) begin
            dataInit[i] = (i * 32'h9E37_79B9) ^ 32'h0BAD_F00D;
            dataMem[i]  = dataInit[i];
        end
        genProgram;
        limit = 0;
        while (finished !== 1'b1 && limit < 40000) begin
            @(posedge clk);
            limit++;
        end
        if (finished !== 1'b1) begin
            $display("timeout: the checker did not finish");
            $display("tests failed");
        end else begin
            $display("reads %0d, writes %0d, errors %0d, assertion failures %0d",
                     readCount, writeCount, errorCount, i_dut.u_sva.failCount);
            if (errorCount == 0 && i_dut.u_sva.failCount == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

// File: filelist.f
src/mipsPkg.sv
src/mipsAlu.sv
src/regFile.sv
src/fetchUnit.sv
src/loadStoreUnit.sv
src/busArbiter.sv
src/cpuControl.sv
src/mipsCpuBus.sv
tb/tbClock.sv
tb/mipsCpuBus_sva.sv
tb/tbChecker.sv
tb/tbTop.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - files:
      - src/mipsPkg.sv
      - src/mipsAlu.sv
      - src/regFile.sv
      - src/fetchUnit.sv
      - src/loadStoreUnit.sv
      - src/busArbiter.sv
      - src/cpuControl.sv
      - src/mipsCpuBus.sv
  - target: simulation
    files:
      - tb/tbClock.sv
      - tb/mipsCpuBus_sva.sv
      - tb/tbChecker.sv
      - tb/tbTop.sv
